// File: design/nn_pkg.sv
// Fixed layer shape of 4 rows by 4 lanes in signed Q8.8; changing the constants alone does not resize the core
package nn_pkg;

    // Stream word with four lanes, lane 0 in the low bits
    typedef logic [63:0] word_t;

    // One signed Q8.8 element
    typedef logic signed [15:0] elem_t;

    // Wide enough for four full products plus the scaled bias
    typedef logic signed [35:0] acc_t;

    // Core write address
    typedef logic [2:0] nn_addr_t;

    localparam int LANES        = 4;  // Elements per word
    localparam int FRAC_BITS    = 8;  // Q8.8 fraction
    localparam int FRAME_WORDS  = 7;  // 4 weights, bias, 2 vectors
    localparam int RESULT_WORDS = 2;  // One result word per vector

    // Write address map
    localparam nn_addr_t ADDR_BIAS = 3'd4;
    localparam nn_addr_t ADDR_VEC0 = 3'd5;
    localparam nn_addr_t ADDR_VEC1 = 3'd6;

    // Largest positive output after saturation
    localparam int OUT_MAX = 32767;

    // Controller to core write
    typedef struct packed {
        nn_addr_t addr;
        word_t    data;
    } nn_wr_t;

    // Output FIFO entry, last sits in bit 0
    typedef struct packed {
        word_t data;
        logic  last;
    } out_beat_t;

endpackage

// File: design/axis_fifo.sv
// Synchronous FWFT FIFO; DEPTH must be a power of two and rd_pop on an empty FIFO is ignored
`timescale 1ns/1ps

module axis_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 16
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [WIDTH-1:0]             wr_data,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    output logic [WIDTH-1:0]             rd_data,
    output logic                         rd_valid,
    input  logic                         rd_pop,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_BITS = $clog2(DEPTH);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic                wr_en;
    logic                rd_en;

    assign wr_ready = (count != DEPTH[$clog2(DEPTH+1)-1:0]);  // Not full
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];                           // Head falls through

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_pop && rd_valid;

    // Storage
    always_ff @(posedge aclk)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
    end

    // Pointers and occupancy
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or push and pop together
            endcase
        end
    end

endmodule

// File: design/dot_product_unit.sv
// Two-cycle latency, one row per cycle; output is ReLU clamped to 0..32767 so negatives never appear
`timescale 1ns/1ps

module dot_product_unit (
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          in_valid,
    input  nn_pkg::word_t weights,
    input  nn_pkg::word_t vector,
    input  nn_pkg::elem_t bias,
    input  logic [2:0]    in_tag,
    output logic          out_valid,
    output nn_pkg::elem_t result,
    output logic [2:0]    out_tag
);

    import nn_pkg::*;

    localparam int   ELEM_BITS = $bits(elem_t);
    localparam acc_t SAT_MAX   = acc_t'(OUT_MAX);

    acc_t       prod_q [LANES];
    elem_t      bias_q;
    logic [2:0] tag_q;
    logic       valid_q;
    acc_t       sum;
    acc_t       scaled;

    // Stage 1 products
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < LANES; i++)
            prod_q[i] <= acc_t'(elem_t'(weights[i * ELEM_BITS +: ELEM_BITS]))
                       * acc_t'(elem_t'(vector[i * ELEM_BITS +: ELEM_BITS]));
        bias_q <= bias;
        tag_q  <= in_tag;
    end

    // Adder tree with bias aligned to the product scale
    always_comb
    begin
        sum = acc_t'(bias_q) <<< FRAC_BITS;
        for (int i = 0; i < LANES; i++)
            sum = sum + prod_q[i];
        scaled = sum >>> FRAC_BITS;  // Back to Q8.8
    end

    // Stage 2 ReLU and saturation
    always_ff @(posedge aclk)
    begin
        if (scaled < 0)
            result <= '0;
        else if (scaled > SAT_MAX)
            result <= elem_t'(SAT_MAX);
        else
            result <= elem_t'(scaled);
        out_tag <= tag_q;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

endmodule

// File: design/nn_core.sv
// One 4x4 layer per start; start is only honoured while ready is high and loads must not overlap a run
`timescale 1ns/1ps

module nn_core (
    input  logic           aclk,
    input  logic           aresetn,
    input  nn_pkg::nn_wr_t wr,
    input  logic           wr_valid,
    input  logic           start,
    output logic           ready,
    input  logic           rd_addr,
    output nn_pkg::word_t  rd_data
);

    import nn_pkg::*;

    localparam int       ELEM_BITS = $bits(elem_t);
    localparam logic [2:0] LAST_PAIR = 3'(RESULT_WORDS * LANES - 1);

    word_t      weight_q [LANES];         // One row per output lane
    word_t      bias_q;
    word_t      vec_q    [RESULT_WORDS];
    word_t      result_q [RESULT_WORDS];
    logic       busy;
    logic [2:0] issue_cnt;                // {vector, row}
    logic [1:0] row;
    logic       vsel;
    elem_t      bias_lane;
    logic       dp_valid;
    elem_t      dp_result;
    logic [2:0] dp_tag;

    assign vsel      = issue_cnt[2];
    assign row       = issue_cnt[1:0];
    assign bias_lane = elem_t'(bias_q[row * ELEM_BITS +: ELEM_BITS]);

    // Parameter and input storage
    always_ff @(posedge aclk)
    begin
        if (wr_valid)
        begin
            case (wr.addr)
                ADDR_BIAS: bias_q   <= wr.data;
                ADDR_VEC0: vec_q[0] <= wr.data;
                ADDR_VEC1: vec_q[1] <= wr.data;
                default:
                begin
                    if (!wr.addr[2])
                        weight_q[wr.addr[1:0]] <= wr.data;  // Rows 0 to 3
                end
            endcase
        end
    end

    // Returning lanes land in their result word
    always_ff @(posedge aclk)
    begin
        if (dp_valid)
            result_q[dp_tag[2]][dp_tag[1:0] * ELEM_BITS +: ELEM_BITS] <= dp_result;
    end

    // Row sequencer
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            busy      <= 1'b0;
            issue_cnt <= '0;
            ready     <= 1'b1;
        end
        else
        begin
            if (start)
            begin
                busy      <= 1'b1;
                issue_cnt <= '0;
                ready     <= 1'b0;
            end
            else if (busy)
            begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == LAST_PAIR)
                    busy <= 1'b0;          // Eighth pair issued
            end
            if (dp_valid && (dp_tag == LAST_PAIR))
                ready <= 1'b1;             // Last result written this cycle
        end
    end

    assign rd_data = result_q[rd_addr];

    dot_product_unit u_dpu (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (busy),
        .weights   (weight_q[row]),
        .vector    (vec_q[vsel]),
        .bias      (bias_lane),
        .in_tag    (issue_cnt),
        .out_valid (dp_valid),
        .result    (dp_result),
        .out_tag   (dp_tag)
    );

endmodule

// File: design/stream_ctrl.sv
// Frames are exactly 7 words; OUT_DEPTH must be at least 2 or the controller never leaves WAIT_CORE
`timescale 1ns/1ps

module stream_ctrl #(
    parameter int IN_DEPTH  = 16,
    parameter int OUT_DEPTH = 8
) (
    input  logic                              aclk,
    input  logic                              aresetn,
    // Input FIFO head
    input  nn_pkg::word_t                     in_data,
    input  logic [$clog2(IN_DEPTH+1)-1:0]     in_count,
    output logic                              in_pop,
    // Core load and start
    output nn_pkg::nn_wr_t                    wr,
    output logic                              wr_valid,
    output logic                              start,
    input  logic                              core_ready,
    // Core result read
    output logic                              rd_addr,
    input  nn_pkg::word_t                     rd_data,
    // Output FIFO write
    output nn_pkg::out_beat_t                 out_beat,
    output logic                              out_push,
    input  logic [$clog2(OUT_DEPTH+1)-1:0]    out_count
);

    import nn_pkg::*;

    typedef enum logic [2:0] {
        WAIT_FRAME,
        LOAD,
        START,
        WAIT_CORE,
        UNLOAD
    } state_t;

    state_t   state;
    state_t   state_next;
    nn_addr_t cnt;
    nn_addr_t cnt_next;
    logic     frame_ready;
    logic     out_room;

    // A whole frame sits in the input FIFO
    assign frame_ready = (in_count >= FRAME_WORDS);

    // Two free entries for the result pair
    assign out_room = (out_count <= (OUT_DEPTH - RESULT_WORDS));

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= WAIT_FRAME;
            cnt   <= '0;
        end
        else
        begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

    always_comb
    begin
        state_next = state;
        cnt_next   = cnt;
        case (state)
            WAIT_FRAME:
            begin
                if (frame_ready)
                begin
                    state_next = LOAD;
                    cnt_next   = '0;
                end
            end
            LOAD:
            begin
                if (cnt == nn_addr_t'(FRAME_WORDS - 1))
                    state_next = START;
                else
                    cnt_next = cnt + 1'b1;
            end
            START:
                state_next = WAIT_CORE;  // Single start strobe
            WAIT_CORE:
            begin
                if (core_ready && out_room)
                begin
                    state_next = UNLOAD;
                    cnt_next   = '0;
                end
            end
            UNLOAD:
            begin
                if (cnt == nn_addr_t'(RESULT_WORDS - 1))
                    state_next = WAIT_FRAME;
                else
                    cnt_next = cnt + 1'b1;
            end
            default:
                state_next = WAIT_FRAME;
        endcase
    end

    // Load path, frame word index doubles as the core address
    assign in_pop   = (state == LOAD);
    assign wr_valid = (state == LOAD);
    assign wr.addr  = cnt;
    assign wr.data  = in_data;

    assign start = (state == START);

    // Unload path, core read is combinational
    assign rd_addr       = cnt[0];
    assign out_push      = (state == UNLOAD);
    assign out_beat.data = rd_data;
    assign out_beat.last = (cnt == nn_addr_t'(RESULT_WORDS - 1));  // Second beat closes frame

endmodule

// File: design/axis_nn_top.sv
// AXI-Stream layer accelerator; slave has no tlast, frames are fixed 7-word, FIFO depths must be powers of two
`timescale 1ns/1ps

module axis_nn_top #(
    parameter int IN_DEPTH  = 16,
    parameter int OUT_DEPTH = 8
) (
    input  logic          aclk,
    input  logic          aresetn,
    // Slave stream
    input  nn_pkg::word_t s_axis_tdata,
    input  logic          s_axis_tvalid,
    output logic          s_axis_tready,
    // Master stream
    output nn_pkg::word_t m_axis_tdata,
    output logic          m_axis_tvalid,
    output logic          m_axis_tlast,
    input  logic          m_axis_tready
);

    import nn_pkg::*;

    word_t                           in_head;
    logic [$clog2(IN_DEPTH+1)-1:0]   in_count;
    logic                            in_pop;
    nn_wr_t                          wr;
    logic                            wr_valid;
    logic                            start;
    logic                            core_ready;
    logic                            rd_addr;
    word_t                           rd_data;
    out_beat_t                       out_beat;
    out_beat_t                       out_head;
    logic                            out_push;
    logic [$clog2(OUT_DEPTH+1)-1:0]  out_count;

    axis_fifo #(
        .WIDTH ($bits(word_t)),
        .DEPTH (IN_DEPTH)
    ) u_in_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_data  (s_axis_tdata),
        .wr_valid (s_axis_tvalid),
        .wr_ready (s_axis_tready),
        .rd_data  (in_head),
        .rd_valid (),               // Controller works from the count
        .rd_pop   (in_pop),
        .count    (in_count)
    );

    stream_ctrl #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) u_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_data    (in_head),
        .in_count   (in_count),
        .in_pop     (in_pop),
        .wr         (wr),
        .wr_valid   (wr_valid),
        .start      (start),
        .core_ready (core_ready),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_beat   (out_beat),
        .out_push   (out_push),
        .out_count  (out_count)
    );

    nn_core u_core (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr       (wr),
        .wr_valid (wr_valid),
        .start    (start),
        .ready    (core_ready),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    axis_fifo #(
        .WIDTH ($bits(out_beat_t)),
        .DEPTH (OUT_DEPTH)
    ) u_out_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_data  (out_beat),
        .wr_valid (out_push),
        .wr_ready (),               // Room is checked before unloading
        .rd_data  (out_head),
        .rd_valid (m_axis_tvalid),
        .rd_pop   (m_axis_tready),
        .count    (out_count)
    );

    assign m_axis_tdata = out_head.data;
    assign m_axis_tlast = out_head.last;

endmodule

// File: testbench/axis_nn_chk.sv
// Bound to axis_nn_top; stream checks are idle while aresetn is low, the reset check is not
`timescale 1ns/1ps

module axis_nn_chk (
    input logic          aclk,
    input logic          aresetn,
    input nn_pkg::word_t m_axis_tdata,
    input logic          m_axis_tvalid,
    input logic          m_axis_tlast,
    input logic          m_axis_tready,
    input logic          start,
    input logic          core_ready
);

    int fail_count = 0;  // Failed assertions so far

    // Stalled beat must hold data and last
    hold_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        (m_axis_tvalid && !m_axis_tready) |=> ($stable(m_axis_tdata) && $stable(m_axis_tlast)))
        else
        begin
            fail_count++;
            $error("m_axis beat changed while stalled");
        end

    // Output FIFO empty after every reset cycle
    reset_quiet: assert property (@(posedge aclk) !aresetn |=> !m_axis_tvalid)
        else
        begin
            fail_count++;
            $error("m_axis_tvalid high during reset");
        end

    start_legal: assert property (@(posedge aclk) disable iff (!aresetn) start |-> core_ready)
        else
        begin
            fail_count++;
            $error("core started while busy");
        end

endmodule

bind axis_nn_top axis_nn_chk chk (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .start         (start),
    .core_ready    (core_ready)
);

// File: testbench/tb_axis_nn.sv
// Expects the default FIFO depths of 16 in and 8 out; the back-pressure test relies on them to stall
`timescale 1ns/1ps

module tb_axis_nn;

    import nn_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 200;   // Cycles for one word to be accepted
    localparam int DRAIN_LIMIT  = 3000;  // Cycles for all expected beats
    localparam int FILL_LIMIT   = 120;   // Words before the input must stall
    localparam int STALL_CYCLES = 40;    // Longer than any gap of a running core

    logic  aclk;
    logic  aresetn;
    word_t s_axis_tdata;
    logic  s_axis_tvalid;
    logic  s_axis_tready;
    word_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tlast;
    logic  m_axis_tready;

    int    seed;
    int    ready_mode;                   // 0 high, 1 random, 2 low
    int    words_sent;
    int    stalled;
    word_t frm [FRAME_WORDS];
    word_t pending [$];
    word_t exp_data [$];
    logic  exp_last [$];

    axis_nn_top #(
        .IN_DEPTH  (16),
        .OUT_DEPTH (8)
    ) uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    always #5 aclk = ~aclk;

    task automatic stop_on_error;
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
            stop_on_error();
        end
    endtask

    // One cycle, then drive the master ready for this mode
    task automatic tick;
        @(posedge aclk);
        #1;
        case (ready_mode)
            0:       m_axis_tready = 1'b1;
            1:       m_axis_tready = 1'($random(seed));
            default: m_axis_tready = 1'b0;
        endcase
    endtask

    function automatic elem_t lane_of(input word_t w, input int k);
        return elem_t'(w[k*16 +: 16]);
    endfunction

    // Frame words 0 to 3 weights, 4 bias, 5 and 6 vectors
    function automatic logic [127:0] ref_layer(input word_t frame [FRAME_WORDS]);
        logic [127:0] res;
        longint       acc;
        res = '0;
        for (int v = 0; v < 2; v++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                acc = longint'(lane_of(frame[4], i)) * 256;
                for (int j = 0; j < 4; j++)
                    acc += longint'(lane_of(frame[i], j)) * longint'(lane_of(frame[5 + v], j));
                acc = acc >>> 8;
                if (acc < 0)
                    acc = 0;                          // ReLU
                else if (acc > 32767)
                    acc = 32767;
                res[v*64 + i*16 +: 16] = 16'(acc);
            end
        end
        return res;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        for (int k = 0; k < 4; k++)
            w[k*16 +: 16] = 16'($random(seed) % 2048);  // About -8.0 to 8.0
        return w;
    endfunction

    task automatic make_random_frame;
        foreach (frm[i])
            frm[i] = rand_word();
    endtask

    task automatic expect_frame(input word_t frame [FRAME_WORDS]);
        logic [127:0] r;
        r = ref_layer(frame);
        exp_data.push_back(r[63:0]);
        exp_last.push_back(1'b0);
        exp_data.push_back(r[127:64]);
        exp_last.push_back(1'b1);
    endtask

    task automatic send_word(input word_t w);
        int waited;
        waited        = 0;
        s_axis_tdata  = w;
        s_axis_tvalid = 1'b1;
        while (!s_axis_tready)
        begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("input word never accepted, s_axis_tready stayed low");
                stop_on_error();
            end
        end
        tick();                                       // Accepted on this edge
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_frame(input word_t frame [FRAME_WORDS]);
        foreach (frame[i])
            send_word(frame[i]);
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (exp_data.size() != 0)
        begin
            tick();
            waited++;
            if (waited > DRAIN_LIMIT)
            begin
                $display("timeout, %0d result beats never arrived", exp_data.size());
                stop_on_error();
            end
        end
    endtask

    // Compare every master beat that transfers
    always @(posedge aclk)
    begin : monitor
        word_t want_data;
        logic  want_last;
        if (aresetn && m_axis_tvalid && m_axis_tready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("result beat at %0t with nothing expected", $time);
                stop_on_error();
            end
            else
            begin
                want_data = exp_data.pop_front();
                want_last = exp_last.pop_front();
                check_word("m_axis_tdata", m_axis_tdata, want_data);
                check_last("m_axis_tlast", m_axis_tlast, want_last);
            end
        end
    end

    // Bound assertions fire on the rising edge
    always @(negedge aclk)
    begin
        if (uut.chk.fail_count != 0)
        begin
            $display("a bound assertion failed before %0t", $time);
            stop_on_error();
        end
    end

    initial
    begin
        seed          = 32'h30e1;
        ready_mode    = 0;
        aclk          = 1'b0;
        aresetn       = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        repeat (RESET_CYCLES) tick();
        aresetn = 1'b1;

        check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_flag("s_axis_tready", s_axis_tready, 1'b1);

        make_random_frame();                          // Single frame
        expect_frame(frm);
        send_frame(frm);
        wait_drain();

        for (int n = 0; n < 20; n++)                  // Back to back
        begin
            make_random_frame();
            expect_frame(frm);
            send_frame(frm);
        end
        wait_drain();

        // Negative sums clamp to zero
        for (int i = 0; i < 4; i++)
            frm[i] = {4{16'h0100}};
        frm[4] = {4{16'hFF00}};
        frm[5] = {4{16'hFF00}};
        frm[6] = '0;
        expect_frame(frm);
        send_frame(frm);
        // Extreme products saturate or clamp
        for (int i = 0; i < 4; i++)
            frm[i] = {4{16'h8000}};
        frm[4] = {4{16'h7FFF}};
        frm[5] = {4{16'h8000}};
        frm[6] = {4{16'h7FFF}};
        expect_frame(frm);
        send_frame(frm);
        wait_drain();

        ready_mode = 1;                               // Random master ready
        for (int n = 0; n < 8; n++)
        begin
            make_random_frame();
            expect_frame(frm);
            send_frame(frm);
        end
        wait_drain();

        // Master held off until the input side stays stalled
        ready_mode = 2;
        words_sent = 0;
        stalled    = 0;
        while (stalled < STALL_CYCLES)
        begin
            if (s_axis_tready)
            begin
                stalled = 0;
                if (pending.size() == 0)
                begin
                    make_random_frame();
                    expect_frame(frm);
                    foreach (frm[i])
                        pending.push_back(frm[i]);
                end
                send_word(pending.pop_front());
                words_sent++;
                if (words_sent > FILL_LIMIT)
                begin
                    $display("s_axis_tready never stayed low with the master stream held off");
                    stop_on_error();
                end
            end
            else
            begin
                tick();
                stalled++;
            end
        end
        ready_mode = 0;
        while (pending.size() != 0)
            send_word(pending.pop_front());           // Rest of the partial frame
        wait_drain();

        repeat (20) tick();                           // Catch stray trailing beats
        if (uut.chk.fail_count == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            $display("a bound assertion failed near the end of the run");
            stop_on_error();
        end
    end

endmodule

// File: sim.f
design/nn_pkg.sv
design/axis_fifo.sv
design/dot_product_unit.sv
design/nn_core.sv
design/stream_ctrl.sv
design/axis_nn_top.sv
testbench/axis_nn_chk.sv
testbench/tb_axis_nn.sv

// File: Makefile
TOP := tb_axis_nn

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
